// ==== Makefile ====
TOP := tb_ooo_core

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): tb.f verilog/*.sv tests/tb_ooo_core.sv
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f tb.f

lint:
	verilator --lint-only -Wall --top-module ooo_core_top \
		verilog/rob_pkg.sv verilog/dispatch_unit.sv verilog/exec_unit.sv \
		verilog/reorder_buffer.sv verilog/retire_unit.sv verilog/ooo_core_top.sv

clean:
	rm -rf obj_dir

// ==== tb.f ====
verilog/rob_pkg.sv
verilog/dispatch_unit.sv
verilog/exec_unit.sv
verilog/reorder_buffer.sv
verilog/retire_unit.sv
verilog/ooo_core_top.sv
tests/tb_ooo_core.sv

// ==== tests/rob_stimulus.mem ====
// insn     op_a     op_b     value    exc
// one instruction per line, all fields hex
A1000010 00001000 DEADBEEF FFFFEFEF 0
02800000 11111111 22222222 33333333 0
03000000 00000005 12345678 00000005 0
24800000 00000010 00000020 FFFFFFF0 0
45800000 F0F0F0F0 FF00FF00 F000F000 0
66800000 AAAA5555 0F0F0F0F A5A55A5A 0
87FFFFF0 00000100 0BADF00D 000000F0 0
22000000 00000042 99999999 00000042 0
60800000 12345678 0000FFFF 1234A987 0
88000001 7FFFFFFF 00000000 80000000 0
A9000004 00002000 00000000 FFFFDFFB 0
AA000008 00002000 00000000 FFFFDFF7 0
ABFFFFF8 12345678 00000000 EDCBA98F 0
AC7FFFFF 00000000 00000000 FF800000 0
AD000010 80000000 00000000 7FFFFFEF 0
A900000C EFFFFFF0 00000000 10000003 0
AE800000 01000000 00000000 FF7FFFFF 0
83000003 00000005 00000000 00000008 0
AF000020 F0000000 00000000 00000000 1
01800000 00000001 00000002 00000003 0
E4000000 00000011 00000022 00000000 2
87000010 00000010 00000000 00000020 0

// ==== tests/tb_ooo_core.sv ====
`timescale 1ns/10ps

module tb_ooo_core
    import rob_pkg::*;
();

    // small buffer so the load burst fills it
    localparam int rob_size    = 4;
    localparam int n_lines     = 22;
    localparam int n_cols      = 5;
    localparam int room_limit  = 100;
    localparam int drain_limit = 400;

    localparam int col_insn  = 0;
    localparam int col_a     = 1;
    localparam int col_b     = 2;
    localparam int col_value = 3;
    localparam int col_exc   = 4;

    logic             clk = 1'b0;
    logic             reset;
    logic             insn_valid;
    insn_u            insn;
    logic [xlen-1:0]  op_a;
    logic [xlen-1:0]  op_b;
    logic [rd_w-1:0]  rf_addr;
    logic             rob_full;
    logic             retire_valid;
    logic [xlen-1:0]  retire_pc;
    logic [rd_w-1:0]  retire_rd;
    logic [xlen-1:0]  retire_value;
    logic [exc_w-1:0] retire_exc;
    logic             trap;
    logic [xlen-1:0]  trap_pc;
    logic [xlen-1:0]  trap_miss_addr;
    logic [xlen-1:0]  retired_count;
    logic [xlen-1:0]  rf_data;

    logic [31:0]     stim [n_lines*n_cols];
    logic [xlen-1:0] rf_expect [32];
    logic [31:0]     rf_written;
    int              expected_q [$];
    logic            saw_full;

    ooo_core_top #(.ROB_SIZE(rob_size)) uut (
        .clk            (clk),
        .reset          (reset),
        .insn_valid     (insn_valid),
        .insn           (insn),
        .op_a           (op_a),
        .op_b           (op_b),
        .rf_addr        (rf_addr),
        .rob_full       (rob_full),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_rd      (retire_rd),
        .retire_value   (retire_value),
        .retire_exc     (retire_exc),
        .trap           (trap),
        .trap_pc        (trap_pc),
        .trap_miss_addr (trap_miss_addr),
        .retired_count  (retired_count),
        .rf_data        (rf_data)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0d ns: %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [31:0] stim_word(input int line, input int col);
        return stim[line * n_cols + col];
    endfunction

    function automatic logic is_load(input int line);
        insn_u w;
        w = stim_word(line, col_insn);
        return w.r_form.opcode == op_load;
    endfunction

    function automatic logic [rd_w-1:0] dest_of(input int line);
        insn_u w;
        w = stim_word(line, col_insn);
        return w.r_form.rd;
    endfunction

    // operand a plus sign-extended 24-bit immediate
    function automatic logic [xlen-1:0] load_address(input int line);
        insn_u w;
        w = stim_word(line, col_insn);
        return stim_word(line, col_a) + {{(xlen-24){w.i_form.imm[23]}}, w.i_form.imm};
    endfunction

    task automatic drive_insn(input int line);
        int waited;
        waited = 0;
        @(posedge clk);
        insn_valid <= 1'b1;
        insn       <= stim_word(line, col_insn);
        op_a       <= stim_word(line, col_a);
        op_b       <= stim_word(line, col_b);
        @(negedge clk);
        // strobe is held until the buffer has room
        while (rob_full) begin
            saw_full = 1'b1;
            if (waited == room_limit) begin
                report_timeout("rob_full stayed high, instruction never dispatched");
            end
            waited++;
            @(negedge clk);
        end
        expected_q.push_back(line);
    endtask

    // in-order retire check
    always @(negedge clk) begin
        int idx;
        if (!reset && retire_valid) begin
            if (expected_q.size() == 0) begin
                $display("Retirement at %0d ns with no instruction outstanding", $time);
                $display("TEST RESULT: FAIL");
                $fatal(1, "extra retirement");
            end else begin
                idx = expected_q.pop_front();
                check_value("retire_pc", retire_pc, idx);
                check_value("retire_rd", retire_rd, dest_of(idx));
                check_value("retire_value", retire_value, stim_word(idx, col_value));
                check_value("retire_exc", retire_exc, stim_word(idx, col_exc));
            end
        end
    end

    initial begin
        int gap;
        int waited;
        int trap_line;
        void'($urandom(32'hc38f));
        reset      = 1'b1;
        insn_valid = 1'b0;
        insn       = '0;
        op_a       = '0;
        op_b       = '0;
        rf_addr    = '0;
        saw_full   = 1'b0;
        rf_written = '0;
        $readmemh("tests/rob_stimulus.mem", stim);

        // register file holds results up to the first exception
        trap_line = -1;
        for (int i = 0; i < n_lines; i++) begin
            if (trap_line < 0) begin
                if (stim_word(i, col_exc) != 0) begin
                    trap_line = i;
                end else if (dest_of(i) != 0) begin
                    rf_expect[dest_of(i)]  = stim_word(i, col_value);
                    rf_written[dest_of(i)] = 1'b1;
                end
            end
        end

        repeat (16) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < n_lines; i++) begin
            drive_insn(i);
            // no idle gap inside a run of loads
            if (is_load(i) && i + 1 < n_lines && is_load(i + 1)) begin
                gap = 0;
            end else begin
                gap = $urandom % 4;
            end
            if (gap > 0 || i == n_lines - 1) begin
                @(posedge clk);
                insn_valid <= 1'b0;
                for (int k = 1; k < gap; k++) begin
                    @(posedge clk);
                end
            end
        end

        waited = 0;
        while (retired_count != n_lines) begin
            if (waited == drain_limit) begin
                report_timeout("not every instruction retired");
            end
            waited++;
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        check_value("retired_count", retired_count, n_lines);
        check_value("outstanding entries", expected_q.size(), 0);
        check_value("rob_full seen", saw_full, 1'b1);
        if (trap_line >= 0) begin
            check_value("trap", trap, 1'b1);
            check_value("trap_pc", trap_pc, trap_line);
            check_value("trap_miss_addr", trap_miss_addr, load_address(trap_line));
        end else begin
            check_value("trap", trap, 1'b0);
        end

        for (int r = 0; r < 32; r++) begin
            if (r == 0 || rf_written[r]) begin
                @(posedge clk);
                rf_addr <= rd_w'(r);
                @(negedge clk);
                check_value($sformatf("rf_data[x%0d]", r), rf_data,
                            (r == 0) ? 32'h0 : rf_expect[r]);
            end
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== verilog/dispatch_unit.sv ====
`timescale 1ns/10ps

module dispatch_unit
    import rob_pkg::*;
#(
    parameter int ROB_SIZE = 10,
    localparam int tag_w = $clog2(ROB_SIZE)
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             insn_valid,
    input  insn_u            insn,
    input  logic [xlen-1:0]  op_a,
    input  logic [xlen-1:0]  op_b,
    input  logic             rob_full,
    input  logic [tag_w-1:0] alloc_idx,
    output logic             alloc,
    output logic [xlen-1:0]  alloc_pc,
    output logic [xlen-1:0]  alloc_miss_addr,
    output logic [rd_w-1:0]  alloc_rd,
    output logic             issue_valid,
    output logic [tag_w-1:0] issue_tag,
    output logic [op_w-1:0]  issue_op,
    output logic [xlen-1:0]  issue_a,
    output logic [xlen-1:0]  issue_b
);

    logic            accept;
    logic [op_w-1:0] opcode;
    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] seq_pc;

    assign accept  = insn_valid && !rob_full;
    assign opcode  = insn.r_form.opcode;
    assign imm_ext = {{(xlen-24){insn.i_form.imm[23]}}, insn.i_form.imm};

    assign alloc       = accept;
    assign issue_valid = accept;
    assign issue_tag   = alloc_idx;
    assign issue_op    = opcode;
    assign alloc_pc    = seq_pc;
    assign alloc_rd    = insn.r_form.rd;

    always_comb begin
        issue_a         = op_a;
        issue_b         = '0;
        alloc_miss_addr = '0;
        case (opcode)
            op_addi: begin
                issue_b = imm_ext;
            end
            op_load: begin
                issue_b         = imm_ext;
                alloc_miss_addr = op_a + imm_ext;
            end
            op_illegal: begin
                issue_a = '0;
            end
            default: begin
                // register form, second source is optional
                issue_b = insn.r_form.rs_sel ? op_b : '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            seq_pc <= '0;
        end else if (accept) begin
            seq_pc <= seq_pc + 1'b1;
        end
    end

endmodule

// ==== verilog/exec_unit.sv ====
`timescale 1ns/10ps

module exec_unit
    import rob_pkg::*;
#(
    parameter int ROB_SIZE = 10,
    localparam int tag_w = $clog2(ROB_SIZE)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              issue_valid,
    input  logic [tag_w-1:0]  issue_tag,
    input  logic [op_w-1:0]   issue_op,
    input  logic [xlen-1:0]   issue_a,
    input  logic [xlen-1:0]   issue_b,
    output logic              complete,
    output logic [tag_w-1:0]  complete_idx,
    output logic [xlen-1:0]   complete_value,
    output logic [exc_w-1:0]  complete_exc
);

    localparam int cnt_w    = 3;
    localparam int lat_fast = 1;
    localparam int lat_load = 6;

    logic [ROB_SIZE-1:0] busy;
    logic [cnt_w-1:0]    cnt [ROB_SIZE];
    logic [xlen-1:0]     val [ROB_SIZE];
    logic [exc_w-1:0]    exc [ROB_SIZE];

    logic [xlen-1:0]  load_addr;
    logic [xlen-1:0]  issue_val;
    logic [exc_w-1:0] issue_exc;
    logic [cnt_w-1:0] issue_cnt;

    // result is fixed at issue, the slot only delays it
    always_comb begin
        load_addr = issue_a + issue_b;
        issue_val = '0;
        issue_exc = exc_none;
        issue_cnt = cnt_w'(lat_fast - 1);
        case (issue_op)
            op_add:  issue_val = issue_a + issue_b;
            op_sub:  issue_val = issue_a - issue_b;
            op_and:  issue_val = issue_a & issue_b;
            op_xor:  issue_val = issue_a ^ issue_b;
            op_addi: issue_val = issue_a + issue_b;
            op_load: begin
                issue_cnt = cnt_w'(lat_load - 1);
                // top region faults
                if (load_addr[xlen-1 -: 4] == 4'hf) begin
                    issue_exc = exc_access;
                end else begin
                    issue_val = ~load_addr;
                end
            end
            default: issue_exc = exc_illegal;
        endcase
    end

    // lowest due slot wins
    always_comb begin
        complete     = 1'b0;
        complete_idx = '0;
        for (int i = ROB_SIZE - 1; i >= 0; i--) begin
            if (busy[i] && cnt[i] == '0) begin
                complete     = 1'b1;
                complete_idx = tag_w'(i);
            end
        end
    end

    assign complete_value = val[complete_idx];
    assign complete_exc   = exc[complete_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            for (int i = 0; i < ROB_SIZE; i++) begin
                if (busy[i] && cnt[i] != '0) begin
                    cnt[i] <= cnt[i] - 1'b1;
                end
            end
            if (complete) begin
                busy[complete_idx] <= 1'b0;
            end
            if (issue_valid) begin
                busy[issue_tag] <= 1'b1;
                cnt[issue_tag]  <= issue_cnt;
                val[issue_tag]  <= issue_val;
                exc[issue_tag]  <= issue_exc;
            end
        end
    end

endmodule

// ==== verilog/ooo_core_top.sv ====
`timescale 1ns/10ps

module ooo_core_top
    import rob_pkg::*;
#(
    parameter int ROB_SIZE = 10,
    localparam int tag_w = $clog2(ROB_SIZE)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              insn_valid,
    input  insn_u             insn,
    input  logic [xlen-1:0]   op_a,
    input  logic [xlen-1:0]   op_b,
    input  logic [rd_w-1:0]   rf_addr,
    output logic              rob_full,
    output logic              retire_valid,
    output logic [xlen-1:0]   retire_pc,
    output logic [rd_w-1:0]   retire_rd,
    output logic [xlen-1:0]   retire_value,
    output logic [exc_w-1:0]  retire_exc,
    output logic              trap,
    output logic [xlen-1:0]   trap_pc,
    output logic [xlen-1:0]   trap_miss_addr,
    output logic [xlen-1:0]   retired_count,
    output logic [xlen-1:0]   rf_data
);

    logic             alloc;
    logic [xlen-1:0]  alloc_pc;
    logic [xlen-1:0]  alloc_miss_addr;
    logic [rd_w-1:0]  alloc_rd;
    logic [tag_w-1:0] alloc_idx;

    logic             issue_valid;
    logic [tag_w-1:0] issue_tag;
    logic [op_w-1:0]  issue_op;
    logic [xlen-1:0]  issue_a;
    logic [xlen-1:0]  issue_b;

    logic             complete;
    logic [tag_w-1:0] complete_idx;
    logic [xlen-1:0]  complete_value;
    logic [exc_w-1:0] complete_exc;

    logic             commit;
    logic [xlen-1:0]  commit_pc;
    logic [xlen-1:0]  commit_value;
    logic [xlen-1:0]  commit_miss_addr;
    logic [rd_w-1:0]  commit_rd;
    logic [exc_w-1:0] commit_exc;

    dispatch_unit #(.ROB_SIZE(ROB_SIZE)) u_dispatch (
        .clk             (clk),
        .reset           (reset),
        .insn_valid      (insn_valid),
        .insn            (insn),
        .op_a            (op_a),
        .op_b            (op_b),
        .rob_full        (rob_full),
        .alloc_idx       (alloc_idx),
        .alloc           (alloc),
        .alloc_pc        (alloc_pc),
        .alloc_miss_addr (alloc_miss_addr),
        .alloc_rd        (alloc_rd),
        .issue_valid     (issue_valid),
        .issue_tag       (issue_tag),
        .issue_op        (issue_op),
        .issue_a         (issue_a),
        .issue_b         (issue_b)
    );

    exec_unit #(.ROB_SIZE(ROB_SIZE)) u_exec (
        .clk            (clk),
        .reset          (reset),
        .issue_valid    (issue_valid),
        .issue_tag      (issue_tag),
        .issue_op       (issue_op),
        .issue_a        (issue_a),
        .issue_b        (issue_b),
        .complete       (complete),
        .complete_idx   (complete_idx),
        .complete_value (complete_value),
        .complete_exc   (complete_exc)
    );

    reorder_buffer #(.ROB_SIZE(ROB_SIZE)) u_rob (
        .clk              (clk),
        .reset            (reset),
        .alloc            (alloc),
        .alloc_pc         (alloc_pc),
        .alloc_miss_addr  (alloc_miss_addr),
        .alloc_rd         (alloc_rd),
        .complete         (complete),
        .complete_idx     (complete_idx),
        .complete_value   (complete_value),
        .complete_exc     (complete_exc),
        .rob_full         (rob_full),
        .alloc_idx        (alloc_idx),
        .commit           (commit),
        .commit_pc        (commit_pc),
        .commit_value     (commit_value),
        .commit_miss_addr (commit_miss_addr),
        .commit_rd        (commit_rd),
        .commit_exc       (commit_exc)
    );

    retire_unit u_retire (
        .clk              (clk),
        .reset            (reset),
        .commit           (commit),
        .commit_pc        (commit_pc),
        .commit_value     (commit_value),
        .commit_miss_addr (commit_miss_addr),
        .commit_rd        (commit_rd),
        .commit_exc       (commit_exc),
        .rf_addr          (rf_addr),
        .retire_valid     (retire_valid),
        .retire_pc        (retire_pc),
        .retire_rd        (retire_rd),
        .retire_value     (retire_value),
        .retire_exc       (retire_exc),
        .trap             (trap),
        .trap_pc          (trap_pc),
        .trap_miss_addr   (trap_miss_addr),
        .retired_count    (retired_count),
        .rf_data          (rf_data)
    );

endmodule

// ==== verilog/reorder_buffer.sv ====
`timescale 1ns/10ps

module reorder_buffer
    import rob_pkg::*;
#(
    parameter int ROB_SIZE = 10,
    localparam int tag_w = $clog2(ROB_SIZE)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              alloc,
    input  logic [xlen-1:0]   alloc_pc,
    input  logic [xlen-1:0]   alloc_miss_addr,
    input  logic [rd_w-1:0]   alloc_rd,
    input  logic              complete,
    input  logic [tag_w-1:0]  complete_idx,
    input  logic [xlen-1:0]   complete_value,
    input  logic [exc_w-1:0]  complete_exc,
    output logic              rob_full,
    output logic [tag_w-1:0]  alloc_idx,
    output logic              commit,
    output logic [xlen-1:0]   commit_pc,
    output logic [xlen-1:0]   commit_value,
    output logic [xlen-1:0]   commit_miss_addr,
    output logic [rd_w-1:0]   commit_rd,
    output logic [exc_w-1:0]  commit_exc
);

    localparam int count_w = $clog2(ROB_SIZE + 1);

    logic [tag_w-1:0]   head;
    logic [tag_w-1:0]   tail;
    logic [count_w-1:0] count;

    logic [ROB_SIZE-1:0] entry_valid;
    logic [ROB_SIZE-1:0] entry_done;
    logic [xlen-1:0]     entry_pc    [ROB_SIZE];
    logic [xlen-1:0]     entry_miss  [ROB_SIZE];
    logic [xlen-1:0]     entry_value [ROB_SIZE];
    logic [rd_w-1:0]     entry_rd    [ROB_SIZE];
    logic [exc_w-1:0]    entry_exc   [ROB_SIZE];

    logic commit_go;

    assign rob_full  = (count == count_w'(ROB_SIZE));
    assign alloc_idx = tail;
    assign commit_go = entry_valid[head] && entry_done[head];

    function automatic logic [tag_w-1:0] wrap_inc(input logic [tag_w-1:0] ptr);
        wrap_inc = (ptr == tag_w'(ROB_SIZE - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            commit      <= 1'b0;
            entry_valid <= '0;
            entry_done  <= '0;
        end else begin
            // full check lives in dispatch
            if (alloc) begin
                entry_valid[tail] <= 1'b1;
                entry_done[tail]  <= 1'b0;
                entry_exc[tail]   <= exc_none;
                entry_pc[tail]    <= alloc_pc;
                entry_miss[tail]  <= alloc_miss_addr;
                entry_rd[tail]    <= alloc_rd;
                tail              <= wrap_inc(tail);
            end

            if (complete) begin
                entry_done[complete_idx]  <= 1'b1;
                entry_value[complete_idx] <= complete_value;
                entry_exc[complete_idx]   <= complete_exc;
            end

            commit <= commit_go;
            if (commit_go) begin
                commit_pc         <= entry_pc[head];
                commit_value      <= entry_value[head];
                commit_miss_addr  <= entry_miss[head];
                commit_rd         <= entry_rd[head];
                commit_exc        <= entry_exc[head];
                entry_valid[head] <= 1'b0;
                head              <= wrap_inc(head);
            end

            case ({alloc, commit_go})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== verilog/retire_unit.sv ====
`timescale 1ns/10ps

module retire_unit
    import rob_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              commit,
    input  logic [xlen-1:0]   commit_pc,
    input  logic [xlen-1:0]   commit_value,
    input  logic [xlen-1:0]   commit_miss_addr,
    input  logic [rd_w-1:0]   commit_rd,
    input  logic [exc_w-1:0]  commit_exc,
    input  logic [rd_w-1:0]   rf_addr,
    output logic              retire_valid,
    output logic [xlen-1:0]   retire_pc,
    output logic [rd_w-1:0]   retire_rd,
    output logic [xlen-1:0]   retire_value,
    output logic [exc_w-1:0]  retire_exc,
    output logic              trap,
    output logic [xlen-1:0]   trap_pc,
    output logic [xlen-1:0]   trap_miss_addr,
    output logic [xlen-1:0]   retired_count,
    output logic [xlen-1:0]   rf_data
);

    logic [xlen-1:0] regs [32];

    assign rf_data = (rf_addr == '0) ? '0 : regs[rf_addr];

    always_ff @(posedge clk) begin
        if (!trap && commit && commit_exc == exc_none && commit_rd != '0) begin
            regs[commit_rd] <= commit_value;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid   <= 1'b0;
            trap           <= 1'b0;
            trap_pc        <= '0;
            trap_miss_addr <= '0;
            retired_count  <= '0;
        end else begin
            retire_valid <= commit;
            if (commit) begin
                retired_count <= retired_count + 1'b1;
                // first exception only, later ones are just reported
                if (!trap && commit_exc != exc_none) begin
                    trap           <= 1'b1;
                    trap_pc        <= commit_pc;
                    trap_miss_addr <= commit_miss_addr;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (commit) begin
            retire_pc    <= commit_pc;
            retire_rd    <= commit_rd;
            retire_value <= commit_value;
            retire_exc   <= commit_exc;
        end
    end

endmodule

// ==== verilog/rob_pkg.sv ====
package rob_pkg;

    localparam int xlen  = 32;
    localparam int op_w  = 3;
    localparam int exc_w = 3;
    localparam int rd_w  = 5;

    // register forms
    localparam logic [op_w-1:0] op_add     = 3'd0;
    localparam logic [op_w-1:0] op_sub     = 3'd1;
    localparam logic [op_w-1:0] op_and     = 3'd2;
    localparam logic [op_w-1:0] op_xor     = 3'd3;
    // immediate forms
    localparam logic [op_w-1:0] op_addi    = 3'd4;
    localparam logic [op_w-1:0] op_load    = 3'd5;
    localparam logic [op_w-1:0] op_illegal = 3'd7;

    localparam logic [exc_w-1:0] exc_none    = 3'd0;
    localparam logic [exc_w-1:0] exc_access  = 3'd1;
    localparam logic [exc_w-1:0] exc_illegal = 3'd2;

    // opcode and rd share the same bits in both views
    typedef union packed {
        struct packed {
            logic [op_w-1:0] opcode;
            logic [rd_w-1:0] rd;
            logic            rs_sel;
            logic [22:0]     unused;
        } r_form;
        struct packed {
            logic [op_w-1:0] opcode;
            logic [rd_w-1:0] rd;
            logic [23:0]     imm;
        } i_form;
    } insn_u;

endpackage
